/* bench/evr_link_monitor_tb.sv */
// link monitor testbench
`default_nettype none
`timescale 1ns/1ps
`include "evr_link_config.svh"

module evr_link_monitor_tb
    import evr_link_pkg::*;
();

    localparam int total_cycles = 10 + 300 + 600 + 2700 + 400 + 1500;
    localparam int watchdog_ns  = (total_cycles + 500) * 8;   // cycles plus margin at 8 ns each

    logic                        clk;
    logic                        rst;
    rx_symbol_t                  rx_sym;
    logic                        reset_done;
    logic                        soft_reset;
    rx_word_t                    rx_out;
    logic                        ready;
    logic                        gt_reset;
    logic [`EVR_RESET_CNT_W-1:0] reset_cnt;

    // reference model state
    link_state_e m_state;
    logic        m_comma, m_err;          // registered flags
    int          m_comma_cnt, m_timeout_cnt;
    logic        m_ready, m_rflag, m_rflag_d;
    logic [`EVR_RESET_CNT_W-1:0] m_reset_cnt;
    logic [15:0] m_out_data;
    logic [1:0]  m_out_k;
    logic        exp_gt;

    logic [31:0] rnd_state = 32'hbb37;
    logic        gt_seen = 1'b0;          // gt_reset as seen by the transceiver
    int          down_cnt = 0;            // cycles left with reset_done low
    int          err_count = 0;
    int          test_errs_start = 0;
    logic [`EVR_RESET_CNT_W-1:0] test_cnt_start = '0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    evr_link_monitor evr_link_monitor_i (
        .clk        (clk),
        .rst        (rst),
        .rx_sym     (rx_sym),
        .reset_done (reset_done),
        .soft_reset (soft_reset),
        .rx_out     (rx_out),
        .ready      (ready),
        .gt_reset   (gt_reset),
        .reset_cnt  (reset_cnt)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rnd_state = xorshift32(rnd_state);
        value     = rnd_state;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic start_test();
        test_errs_start = err_count;
        test_cnt_start  = m_reset_cnt;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_count - test_errs_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    // transceiver drops reset_done for 8 to 40 cycles after each gt_reset
    task automatic model_transceiver();
        logic [31:0] r;
        if (gt_seen === 1'b1) begin
            next_random(r);
            down_cnt   = 8 + (r % 33);
            reset_done = 1'b0;
        end else if (down_cnt > 0) begin
            down_cnt--;
            if (down_cnt == 0) begin
                reset_done = 1'b1;
            end
        end
    endtask

    // rates are out of 256
    // err_at forces one error at that cycle index
    task automatic run_test(input int cycles, input int comma_rate, input int hi_rate,
                            input int err_rate, input int soft_rate,
                            input int comma_from, input int err_at);
        rx_symbol_t  sym;
        logic [31:0] r_data, r_pick, r_err;
        logic        want_comma, want_hi, want_err;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            model_transceiver();
            next_random(r_data);
            next_random(r_pick);
            sym            = '0;
            sym.data       = r_data[15:0];
            sym.charisk    = r_data[17:16];
            want_comma     = (i >= comma_from) && (r_pick[7:0] < comma_rate);
            want_hi        = r_pick[15:8] < hi_rate;
            want_err       = (r_pick[23:16] < err_rate) || (i == err_at);
            if (want_comma) begin
                sym.data[7:0]  = `EVR_COMMA_CHAR;
                sym.charisk[0] = 1'b1;
            end else if (sym.data[7:0] == `EVR_COMMA_CHAR) begin
                sym.charisk[0] = 1'b0;   // no accidental comma
            end
            if (want_hi) begin
                sym.data[15:8] = `EVR_COMMA_CHAR;   // must not count
                sym.charisk[1] = 1'b1;
            end
            if (want_err) begin
                next_random(r_err);
                if (r_err[0]) begin
                    sym.disperr[r_err[1]] = 1'b1;
                end else begin
                    sym.notintable[r_err[1]] = 1'b1;
                end
            end
            soft_reset = r_pick[31:24] < soft_rate;
            rx_sym     = sym;
        end
    endtask

    // ------------------------------------------------------------
    // reference model updated on each rising edge
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            m_state       <= CHECK;
            m_comma       <= 1'b0;
            m_err         <= 1'b0;
            m_comma_cnt   <= 0;
            m_timeout_cnt <= 0;
            m_ready       <= 1'b0;
            m_rflag       <= 1'b0;
            m_rflag_d     <= 1'b0;
            m_reset_cnt   <= '0;
            m_out_data    <= '0;
            m_out_k       <= '0;
        end else begin
            case (m_state)
                READY: if (m_err) m_state <= RESET;
                RESET: if (reset_done) m_state <= CHECK;
                default: begin
                    if (m_comma_cnt == `EVR_COMMAS_NEEDED && reset_done) begin
                        m_state <= READY;
                    end else if (m_timeout_cnt == `EVR_CHECK_TIMEOUT) begin
                        m_state <= RESET;
                    end
                end
            endcase
            if (m_state == RESET) begin
                m_comma_cnt   <= 0;
                m_timeout_cnt <= 0;
            end else if (m_state == CHECK) begin
                if (m_comma && m_comma_cnt < `EVR_COMMAS_NEEDED) m_comma_cnt <= m_comma_cnt + 1;
                if (m_timeout_cnt < `EVR_CHECK_TIMEOUT) m_timeout_cnt <= m_timeout_cnt + 1;
            end else begin
                m_timeout_cnt <= 0;   // comma count holds in READY
            end
            m_ready   <= (m_state == READY);
            m_rflag   <= (m_state == RESET);
            m_rflag_d <= m_rflag;
            if (m_rflag && !m_rflag_d) m_reset_cnt <= m_reset_cnt + 1;
            m_out_data <= m_ready ? rx_sym.data : 16'h0000;
            m_out_k    <= rx_sym.charisk;
            m_comma    <= rx_sym.charisk[0] && (rx_sym.data[7:0] == `EVR_COMMA_CHAR);
            m_err      <= (rx_sym.disperr != 2'b00) || (rx_sym.notintable != 2'b00);
        end
    end

    // compare at the falling edge where all outputs have settled
    always @(negedge clk) begin
        gt_seen = gt_reset;
        if (rst === 1'b0) begin
            exp_gt = (m_rflag && !m_rflag_d) || soft_reset;
            if (rx_out.data !== m_out_data)
                report_mismatch("rx_out.data", rx_out.data, m_out_data);
            if (rx_out.charisk !== m_out_k)
                report_mismatch("rx_out.charisk", rx_out.charisk, m_out_k);
            if (ready !== m_ready)
                report_mismatch("ready", ready, m_ready);
            if (gt_reset !== exp_gt)
                report_mismatch("gt_reset", gt_reset, exp_gt);
            if (reset_cnt !== m_reset_cnt)
                report_mismatch("reset_cnt", reset_cnt, m_reset_cnt);
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        rx_sym     = '0;
        reset_done = 1'b1;
        soft_reset = 1'b0;
        wait (rst === 1'b0);
        @(negedge clk);

        start_test();
        if (ready !== 1'b0) report_mismatch("ready", ready, 0);
        if (gt_reset !== 1'b0) report_mismatch("gt_reset", gt_reset, 0);
        if (reset_cnt !== '0) report_mismatch("reset_cnt", reset_cnt, 0);
        if (rx_out.data !== 16'h0000) report_mismatch("rx_out.data", rx_out.data, 0);
        run_test(10, 0, 0, 0, 0, 0, -1);
        if (ready !== 1'b0 || reset_cnt !== '0) begin
            $display("test reset_state: link left its reset state without commas");
            err_count++;
        end
        end_test("reset_state");

        start_test();
        run_test(300, 128, 64, 0, 0, 0, -1);   // commas in both bytes
        if (ready !== 1'b1) begin
            $display("test alignment: ready did not come up");
            err_count++;
        end
        end_test("alignment");

        start_test();
        run_test(600, 128, 0, 0, 0, 0, 200);   // one error while ready
        if (ready !== 1'b1 || reset_cnt !== test_cnt_start + 1) begin
            $display("test error_recovery: no single reset and realignment after the error");
            err_count++;
        end
        end_test("error_recovery");

        start_test();
        run_test(2700, 128, 64, 0, 0, 2300, 0);   // no commas until 2300
        if (ready !== 1'b1 || reset_cnt !== test_cnt_start + 3) begin
            $display("test timeout: expected two timeouts and realignment");
            err_count++;
        end
        end_test("timeout");

        start_test();
        run_test(400, 128, 0, 0, 16, 0, -1);
        if (ready !== 1'b1 || reset_cnt !== test_cnt_start) begin
            $display("test soft_reset: soft reset disturbed the link state or the count");
            err_count++;
        end
        end_test("soft_reset");

        start_test();
        run_test(1500, 128, 64, 1, 4, 0, -1);   // everything mixed
        end_test("kflag_random");

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// testbench clock and reset
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period = 4;   // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // synchronous reset held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;   // released with the other inputs
    end

endmodule

`default_nettype wire

/* hdl/align_timer.sv */
// comma counter and check timeout
`default_nettype none
`timescale 1ns/1ps
`include "evr_link_config.svh"

module align_timer
    import evr_link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  link_state_e   state,    // current fsm state
    input  symbol_flags_t flags,    // registered detector results
    output align_status_t align     // limits reached
);

    // limits sized to their counters
    localparam logic [`EVR_COMMA_CNT_W-1:0] comma_limit   = `EVR_COMMAS_NEEDED;
    localparam logic [`EVR_TIMEOUT_W-1:0]   timeout_limit = `EVR_CHECK_TIMEOUT;
    localparam logic [`EVR_COMMA_CNT_W-1:0] comma_step    = 1;
    localparam logic [`EVR_TIMEOUT_W-1:0]   timeout_step  = 1;

    logic [`EVR_COMMA_CNT_W-1:0] comma_cnt;    // low-byte commas seen in CHECK
    logic [`EVR_TIMEOUT_W-1:0]   timeout_cnt;  // cycles spent in CHECK

    // ----------------------------------------------------------
    // limit compares
    // ----------------------------------------------------------
    always_comb begin
        align             = '0;
        align.commas_done = (comma_cnt == comma_limit);
        align.timed_out   = (timeout_cnt == timeout_limit);
    end

    // ----------------------------------------------------------
    // counters, steered by state
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            comma_cnt   <= '0;
            timeout_cnt <= '0;
        end else begin
            case (state)
                RESET: begin
                    // fresh start after every transceiver reset
                    comma_cnt   <= '0;
                    timeout_cnt <= '0;
                end
                CHECK: begin
                    if (flags.comma_seen && !align.commas_done) begin
                        comma_cnt <= comma_cnt + comma_step;   // saturates at limit
                    end
                    if (!align.timed_out) begin
                        timeout_cnt <= timeout_cnt + timeout_step;
                    end
                end
                default: begin
                    // READY: comma count holds
                    timeout_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/evr_link_config.svh */
// event receiver link settings
`ifndef EVR_LINK_CONFIG_SVH
`define EVR_LINK_CONFIG_SVH

// alignment
`define EVR_COMMAS_NEEDED   60      // low-byte commas needed in CHECK before READY
`define EVR_COMMA_CHAR      8'hBC   // K28.5
`define EVR_COMMA_CNT_W     8       // comma counter, holds up to 255

// check timeout, in clk cycles
// short enough for simulation, hardware at 125 MHz would use about 1 ms
`define EVR_CHECK_TIMEOUT   1000
`define EVR_TIMEOUT_W       18      // room for the long hardware timeout

// reset pulse statistics
`define EVR_RESET_CNT_W     32

`endif

/* hdl/evr_link_monitor.sv */
// event receiver link monitor
`default_nettype none
`timescale 1ns/1ps
`include "evr_link_config.svh"

module evr_link_monitor
    import evr_link_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    // decoded stream and status from the transceiver
    input  rx_symbol_t                  rx_sym,
    input  logic                        reset_done,

    // control bus
    input  logic                        soft_reset,

    // to the event decoder
    output rx_word_t                    rx_out,
    output logic                        ready,

    // back to the transceiver and status
    output logic                        gt_reset,
    output logic [`EVR_RESET_CNT_W-1:0] reset_cnt
);

    // ----------------------------------------------------------
    // internal links
    // ----------------------------------------------------------
    symbol_flags_t flags;   // detector to fsm and timer
    link_state_e   state;   // fsm to timer
    align_status_t align;   // timer to fsm

    // comma and error detection, gated output word
    rx_symbol_path rx_symbol_path_i (
        .clk    (clk),
        .rst    (rst),
        .rx_sym (rx_sym),
        .ready  (ready),
        .flags  (flags),
        .rx_out (rx_out)
    );

    // comma count and check timeout
    align_timer align_timer_i (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .flags (flags),
        .align (align)
    );

    // state machine, reset pulse and pulse count
    link_reset_fsm link_reset_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .flags      (flags),
        .align      (align),
        .reset_done (reset_done),
        .soft_reset (soft_reset),
        .state      (state),
        .ready      (ready),
        .gt_reset   (gt_reset),
        .reset_cnt  (reset_cnt)
    );

endmodule

`default_nettype wire

/* hdl/evr_link_pkg.sv */
// event receiver link types
`default_nettype none

package evr_link_pkg;

    // ----------------------------------------------------------
    // link supervisor states
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        READY = 2'd0,   // aligned, data passes
        RESET = 2'd1,   // waiting for transceiver reset done
        CHECK = 2'd2    // counting commas
    } link_state_e;

    // ----------------------------------------------------------
    // symbol stream
    // ----------------------------------------------------------
    // decoded transceiver output, two bytes per cycle
    typedef struct packed {
        logic [15:0] data;          // byte 1 high, byte 0 low
        logic [1:0]  charisk;       // K flag per byte
        logic [1:0]  disperr;       // running disparity error per byte
        logic [1:0]  notintable;    // invalid 10b code per byte
    } rx_symbol_t;

    // word handed to the event decoder
    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  charisk;
    } rx_word_t;

    // registered detector results
    typedef struct packed {
        logic comma_seen;   // K28.5 in the low byte
        logic error_seen;   // any decode error on either byte
    } symbol_flags_t;

    // counter limits reached, timer to fsm
    typedef struct packed {
        logic commas_done;
        logic timed_out;
    } align_status_t;

endpackage

`default_nettype wire

/* hdl/link_reset_fsm.sv */
// link supervisor state machine
`default_nettype none
`timescale 1ns/1ps
`include "evr_link_config.svh"

module link_reset_fsm
    import evr_link_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  symbol_flags_t               flags,      // registered comma and error
    input  align_status_t               align,      // counter limits from the timer
    input  logic                        reset_done, // level from the transceiver
    input  logic                        soft_reset, // level from the control bus
    output link_state_e                 state,
    output logic                        ready,      // aligned, one cycle behind state
    output logic                        gt_reset,   // reset request to the transceiver
    output logic [`EVR_RESET_CNT_W-1:0] reset_cnt   // number of fsm reset pulses
);

    localparam logic [`EVR_RESET_CNT_W-1:0] cnt_step = 1;

    link_state_e next_state;
    logic        reset_flag;    // state was RESET last cycle
    logic        reset_flag_d;  // one more cycle back
    logic        reset_pulse;   // rising edge of reset_flag

    // ----------------------------------------------------------
    // state register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CHECK;   // start by looking for commas
        end else begin
            state <= next_state;
        end
    end

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            READY: begin
                if (flags.error_seen) begin
                    next_state = RESET;   // any decode error drops the link
                end
            end
            RESET: begin
                if (reset_done) begin
                    next_state = CHECK;
                end
            end
            CHECK: begin
                // enough commas wins over the timeout in the same cycle
                if (align.commas_done && reset_done) begin
                    next_state = READY;
                end else if (align.timed_out) begin
                    next_state = RESET;
                end
            end
            default: begin
                next_state = RESET;   // unused encoding, recover through reset
            end
        endcase
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ready        <= 1'b0;
            reset_flag   <= 1'b0;
            reset_flag_d <= 1'b0;
            reset_cnt    <= '0;
        end else begin
            ready        <= (state == READY);
            reset_flag   <= (state == RESET);
            reset_flag_d <= reset_flag;
            if (reset_pulse) begin
                reset_cnt <= reset_cnt + cnt_step;   // shows up the cycle after the pulse
            end
        end
    end

    // single cycle strobe per entry into RESET
    assign reset_pulse = reset_flag && !reset_flag_d;

    // soft reset goes straight to the transceiver
    // it is not counted and leaves the state alone
    assign gt_reset = reset_pulse || soft_reset;

endmodule

`default_nettype wire

/* hdl/rx_symbol_path.sv */
// symbol detector and output word
`default_nettype none
`timescale 1ns/1ps
`include "evr_link_config.svh"

module rx_symbol_path
    import evr_link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  rx_symbol_t    rx_sym,   // one decoded symbol per cycle
    input  logic          ready,    // registered aligned level from the fsm
    output symbol_flags_t flags,    // detector results, one cycle late
    output rx_word_t      rx_out    // data zeroed while not aligned
);

    // ----------------------------------------------------------
    // detection
    // ----------------------------------------------------------
    logic          comma_lo;    // K28.5 in byte 0
    logic          decode_err;  // decoder complaint on any byte
    symbol_flags_t flags_next;

    // alignment comma only counts in the low byte
    // commas in the high byte are legal protocol codes on the data bus
    assign comma_lo = rx_sym.charisk[0] && (rx_sym.data[7:0] == `EVR_COMMA_CHAR);

    // not-in-table or disparity, either byte
    assign decode_err = (rx_sym.notintable != 2'b00) || (rx_sym.disperr != 2'b00);

    always_comb begin
        flags_next            = '0;
        flags_next.comma_seen = comma_lo;
        flags_next.error_seen = decode_err;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= flags_next;   // aligned with rx_out timing
        end
    end

    // ----------------------------------------------------------
    // output word
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_out <= '0;
        end else begin
            // event codes only pass while the link is up
            rx_out.data    <= ready ? rx_sym.data : 16'h0000;
            rx_out.charisk <= rx_sym.charisk;   // k flags pass regardless
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/evr_link_pkg.sv
hdl/rx_symbol_path.sv
hdl/align_timer.sv
hdl/link_reset_fsm.sv
hdl/evr_link_monitor.sv
bench/tb_clock_gen.sv
bench/evr_link_monitor_tb.sv
